//--- chess_types_pkg.sv
`default_nettype none

package chess_types_pkg;

    localparam int SQUARE_BITS = 6;
    localparam int PIECE_BITS  = 4;
    localparam int EVAL_BITS   = 16;

    // square index 0 to 63
    typedef logic [SQUARE_BITS-1:0] square_t;

    // promo is zero for a plain move
    typedef struct packed {
        square_t               from_sq;
        square_t               to_sq;
        logic [PIECE_BITS-1:0] promo;
    } move_t;

    // centipawns, higher is better for the side to move
    typedef logic signed [EVAL_BITS-1:0] eval_t;

endpackage

`default_nettype wire

//--- move_order_pkg.sv
`default_nettype none

package move_order_pkg;

    localparam int MAX_MOVES   = 63;
    localparam int MAX_DEPTH   = 32;
    localparam int NUM_SORTERS = 2;

    localparam int DEPTH_BITS = $clog2(MAX_DEPTH);
    localparam int IDX_BITS   = $clog2(MAX_MOVES + 1);
    localparam int LEN_BITS   = IDX_BITS + 1;

    // one slot of 2**IDX_BITS words per depth
    localparam int RAM_DEPTH = MAX_DEPTH * (1 << IDX_BITS);

    // read register plus output register
    localparam int READ_LATENCY = 2;

    typedef logic [DEPTH_BITS-1:0]          depth_t;
    typedef logic [IDX_BITS-1:0]            move_idx_t;
    typedef logic [LEN_BITS-1:0]            list_len_t;
    typedef logic [DEPTH_BITS+IDX_BITS-1:0] stack_addr_t;

endpackage

`default_nettype wire

//--- stream_sorter.sv
`timescale 1ns/1ps
`default_nettype none

module stream_sorter (
    input  wire                         clk_in,
    input  wire                         rst_in,
    input  wire chess_types_pkg::move_t move_in,
    input  wire chess_types_pkg::eval_t eval_in,
    input  wire                         insert_in,
    input  wire                         dequeue_in,
    output chess_types_pkg::move_t      top_move,
    output move_order_pkg::list_len_t   len
);
    import move_order_pkg::*;
    import chess_types_pkg::*;

    move_t     moves [MAX_MOVES];
    eval_t     evals [MAX_MOVES];
    list_len_t count;

    // set from the insert point to the end, list kept in descending order
    logic [MAX_MOVES-1:0] hole;

    always_comb begin
        for (int i = 0; i < MAX_MOVES; i++) begin
            // strict compare so equal scores stay behind earlier arrivals
            hole[i] = (i >= count) || (evals[i] < eval_in);
        end
    end

    always_ff @(posedge clk_in) begin
        if (dequeue_in) begin
            for (int i = 0; i < MAX_MOVES - 1; i++) begin
                moves[i] <= moves[i + 1];
                evals[i] <= evals[i + 1];
            end
        end else if (insert_in) begin
            if (hole[0]) begin
                moves[0] <= move_in;
                evals[0] <= eval_in;
            end
            // a full list pushes its last entry off the end
            for (int i = 1; i < MAX_MOVES; i++) begin
                if (hole[i - 1]) begin
                    moves[i] <= moves[i - 1];
                    evals[i] <= evals[i - 1];
                end else if (hole[i]) begin
                    moves[i] <= move_in;
                    evals[i] <= eval_in;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count <= '0;
        end else if (dequeue_in) begin
            if (count != '0) begin
                count <= count - 1'b1;
            end
        end else if (insert_in) begin
            if (count != list_len_t'(MAX_MOVES)) begin
                count <= count + 1'b1;
            end
        end
    end

    assign top_move = moves[0];
    assign len      = count;

endmodule

`default_nettype wire

//--- sorter_drain_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sorter_drain_arbiter (
    input  wire                          clk_in,
    input  wire                          rst_in,
    input  wire                          open_in,
    input  wire                          close_in,
    input  wire move_order_pkg::depth_t  depth_in,
    input  wire                          move_valid_in,
    input  wire move_order_pkg::list_len_t [move_order_pkg::NUM_SORTERS-1:0] sort_len,
    input  wire chess_types_pkg::move_t [move_order_pkg::NUM_SORTERS-1:0]    sort_top_move,
    output logic [move_order_pkg::NUM_SORTERS-1:0] insert,
    output logic [move_order_pkg::NUM_SORTERS-1:0] dequeue,
    output logic                         wr_en,
    output move_order_pkg::stack_addr_t  wr_addr,
    output chess_types_pkg::move_t       wr_move,
    output logic                         free_out,
    output logic                         idle_out,
    output move_order_pkg::list_len_t    list_len_out,
    output logic                         list_len_valid_out
);
    import move_order_pkg::*;
    import chess_types_pkg::*;

    // busy from open until the sorter is empty again
    logic [NUM_SORTERS-1:0] busy;
    logic [NUM_SORTERS-1:0] filling;
    logic [NUM_SORTERS-1:0] draining;
    logic [NUM_SORTERS-1:0] open_pick;
    logic [NUM_SORTERS-1:0] drain_pick;

    depth_t    [NUM_SORTERS-1:0] sort_depth;
    move_idx_t [NUM_SORTERS-1:0] drain_idx;

    depth_t    drain_depth;
    move_idx_t drain_pos;
    move_t     drain_move;
    list_len_t fill_len;

    always_comb begin
        logic found_free;
        logic found_drain;
        found_free  = 1'b0;
        found_drain = 1'b0;
        open_pick   = '0;
        drain_pick  = '0;
        drain_depth = '0;
        drain_pos   = '0;
        drain_move  = '0;
        fill_len    = '0;
        for (int i = 0; i < NUM_SORTERS; i++) begin
            if (!found_free && !busy[i] && sort_len[i] == '0) begin
                found_free   = 1'b1;
                open_pick[i] = 1'b1;
            end
            // closed and still holding moves
            if (!found_drain && busy[i] && !filling[i] && sort_len[i] != '0) begin
                found_drain   = 1'b1;
                drain_pick[i] = 1'b1;
            end
            // draining and filling are one-hot, so OR works as a mux
            if (draining[i]) begin
                drain_depth = drain_depth | sort_depth[i];
                drain_pos   = drain_pos | drain_idx[i];
                drain_move  = drain_move | sort_top_move[i];
            end
            if (filling[i]) begin
                fill_len = fill_len | sort_len[i];
            end
            insert[i]  = filling[i] && move_valid_in;
            dequeue[i] = draining[i] && sort_len[i] != '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy               <= '0;
            filling            <= '0;
            draining           <= '0;
            drain_idx          <= '0;
            wr_en              <= 1'b0;
            list_len_valid_out <= 1'b0;
        end else begin
            for (int i = 0; i < NUM_SORTERS; i++) begin
                if (open_in && open_pick[i]) begin
                    busy[i]      <= 1'b1;
                    filling[i]   <= 1'b1;
                    drain_idx[i] <= '0;
                end
                if (close_in && filling[i]) begin
                    filling[i] <= 1'b0;
                    // an empty list hands its sorter back right away
                    if (sort_len[i] == '0) begin
                        busy[i] <= 1'b0;
                    end
                end
                if (draining == '0 && drain_pick[i]) begin
                    draining[i] <= 1'b1;
                end
                if (dequeue[i]) begin
                    drain_idx[i] <= drain_idx[i] + 1'b1;
                    if (sort_len[i] == list_len_t'(1)) begin
                        draining[i] <= 1'b0;
                        busy[i]     <= 1'b0;
                    end
                end
            end
            wr_en              <= |dequeue;
            list_len_valid_out <= close_in && |filling;
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < NUM_SORTERS; i++) begin
            if (open_in && open_pick[i]) begin
                sort_depth[i] <= depth_in;
            end
        end
        wr_addr      <= {drain_depth, drain_pos};
        wr_move      <= drain_move;
        list_len_out <= fill_len;
    end

    assign free_out = |open_pick;
    // wait for the last write to land before reporting idle
    assign idle_out = !(|busy) && !wr_en;

endmodule

`default_nettype wire

//--- move_stack_ram.sv
`timescale 1ns/1ps
`default_nettype none

module move_stack_ram (
    input  wire                              clk_in,
    input  wire                              wr_en,
    input  wire move_order_pkg::stack_addr_t wr_addr,
    input  wire chess_types_pkg::move_t      wr_move,
    input  wire move_order_pkg::stack_addr_t rd_addr,
    output chess_types_pkg::move_t           rd_move
);
    import move_order_pkg::*;
    import chess_types_pkg::*;

    move_t mem [RAM_DEPTH];

    // stage 0 is the read register, the last stage drives rd_move
    move_t rd_pipe [READ_LATENCY];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_move;
        end
    end

    // a read of the address being written returns the old word
    always_ff @(posedge clk_in) begin
        rd_pipe[0] <= mem[rd_addr];
        for (int k = 1; k < READ_LATENCY; k++) begin
            rd_pipe[k] <= rd_pipe[k - 1];
        end
    end

    assign rd_move = rd_pipe[READ_LATENCY - 1];

endmodule

`default_nettype wire

//--- move_order_unit.sv
`timescale 1ns/1ps
`default_nettype none

module move_order_unit (
    input  wire                             clk_in,
    input  wire                             rst_in,
    input  wire                             open_in,
    input  wire                             close_in,
    input  wire move_order_pkg::depth_t     depth_in,
    input  wire chess_types_pkg::move_t     move_in,
    input  wire chess_types_pkg::eval_t     eval_in,
    input  wire                             move_valid_in,
    input  wire move_order_pkg::depth_t     read_depth_in,
    input  wire move_order_pkg::move_idx_t  read_idx_in,
    output chess_types_pkg::move_t          read_move_out,
    output logic                            free_out,
    output logic                            idle_out,
    output move_order_pkg::list_len_t       list_len_out,
    output logic                            list_len_valid_out
);
    import move_order_pkg::*;
    import chess_types_pkg::*;

    list_len_t [NUM_SORTERS-1:0] sort_len;
    move_t     [NUM_SORTERS-1:0] sort_top_move;
    logic      [NUM_SORTERS-1:0] insert;
    logic      [NUM_SORTERS-1:0] dequeue;

    logic        wr_en;
    stack_addr_t wr_addr;
    move_t       wr_move;

    // all sorters see the same move, only the filling one takes it
    for (genvar i = 0; i < NUM_SORTERS; i++) begin : g_sorter
        stream_sorter u_sorter (
            .clk_in     (clk_in),
            .rst_in     (rst_in),
            .move_in    (move_in),
            .eval_in    (eval_in),
            .insert_in  (insert[i]),
            .dequeue_in (dequeue[i]),
            .top_move   (sort_top_move[i]),
            .len        (sort_len[i])
        );
    end

    sorter_drain_arbiter u_arbiter (
        .clk_in             (clk_in),
        .rst_in             (rst_in),
        .open_in            (open_in),
        .close_in           (close_in),
        .depth_in           (depth_in),
        .move_valid_in      (move_valid_in),
        .sort_len           (sort_len),
        .sort_top_move      (sort_top_move),
        .insert             (insert),
        .dequeue            (dequeue),
        .wr_en              (wr_en),
        .wr_addr            (wr_addr),
        .wr_move            (wr_move),
        .free_out           (free_out),
        .idle_out           (idle_out),
        .list_len_out       (list_len_out),
        .list_len_valid_out (list_len_valid_out)
    );

    move_stack_ram u_move_stack (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_move (wr_move),
        .rd_addr ({read_depth_in, read_idx_in}),
        .rd_move (read_move_out)
    );

endmodule

`default_nettype wire

//--- tb_move_order_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_move_order_unit;
    import chess_types_pkg::*;
    import move_order_pkg::*;

    // moves sent, reads issued, and room per list for drain and waits
    localparam int TOTAL_MOVES    = 40 + 30 + 25 + 35 + 70 + 20;
    localparam int TOTAL_READS    = 40 + 30 + 25 + 35 + 63 + 63 + 20;
    localparam int NUM_LISTS      = 7;
    localparam int LIST_MARGIN    = 150;
    localparam int TIMEOUT_CYCLES = TOTAL_MOVES + TOTAL_READS + NUM_LISTS * LIST_MARGIN;

    logic      clk_in;
    logic      rst_in;
    logic      open_in;
    logic      close_in;
    depth_t    depth_in;
    move_t     move_in;
    eval_t     eval_in;
    logic      move_valid_in;
    depth_t    read_depth_in;
    move_idx_t read_idx_in;
    move_t     read_move_out;
    logic      free_out;
    logic      idle_out;
    list_len_t list_len_out;
    logic      list_len_valid_out;

    integer seed;
    int     cycle_count = 0;
    int     error_count;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;
    string  test_name;

    // list being built, then the reference contents per depth slot
    move_t  cur_move [64];
    eval_t  cur_eval [64];
    int     cur_len;
    move_t  slot_move [MAX_DEPTH][64];
    int     slot_len [MAX_DEPTH];

    depth_t d2;

    move_order_unit uut (
        .clk_in             (clk_in),
        .rst_in             (rst_in),
        .open_in            (open_in),
        .close_in           (close_in),
        .depth_in           (depth_in),
        .move_in            (move_in),
        .eval_in            (eval_in),
        .move_valid_in      (move_valid_in),
        .read_depth_in      (read_depth_in),
        .read_idx_in        (read_idx_in),
        .read_move_out      (read_move_out),
        .free_out           (free_out),
        .idle_out           (idle_out),
        .list_len_out       (list_len_out),
        .list_len_valid_out (list_len_valid_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic check_value(input string label, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", label, expected, actual);
            error_count++;
        end
    endtask

    // stable descending insert, a full list only takes a strictly better score
    task automatic model_insert(input move_t m, input eval_t e);
        int pos;
        pos = 0;
        while (pos < cur_len && cur_eval[pos] >= e) begin
            pos++;
        end
        if (pos < MAX_MOVES) begin
            for (int i = MAX_MOVES - 1; i > pos; i--) begin
                cur_move[i] = cur_move[i - 1];
                cur_eval[i] = cur_eval[i - 1];
            end
            cur_move[pos] = m;
            cur_eval[pos] = e;
            if (cur_len < MAX_MOVES) begin
                cur_len++;
            end
        end
    endtask

    task automatic run_list(input depth_t d, input int n, input bit three_vals);
        move_t m;
        eval_t e;
        @(negedge clk_in);
        while (!free_out) begin
            @(negedge clk_in);
        end
        @(posedge clk_in);
        open_in  <= 1'b1;
        depth_in <= d;
        cur_len = 0;
        for (int k = 0; k < n; k++) begin
            @(posedge clk_in);
            open_in <= 1'b0;
            m = move_t'($random(seed));
            if (three_vals) begin
                case ({$random(seed)} % 3)
                    0: e = -16'sd40;
                    1: e = 16'sd0;
                    default: e = 16'sd95;
                endcase
            end else begin
                e = eval_t'($random(seed));
            end
            move_in       <= m;
            eval_in       <= e;
            move_valid_in <= 1'b1;
            model_insert(m, e);
        end
        @(posedge clk_in);
        open_in       <= 1'b0;
        move_valid_in <= 1'b0;
        close_in      <= 1'b1;
        @(posedge clk_in);
        close_in <= 1'b0;
        @(negedge clk_in);
        check_value({test_name, " len valid"}, 16'd1, 16'(list_len_valid_out));
        check_value({test_name, " len"}, 16'(cur_len), 16'(list_len_out));
        // an empty list writes nothing, so the slot keeps its old contents
        if (cur_len != 0) begin
            slot_len[d] = cur_len;
            for (int i = 0; i < cur_len; i++) begin
                slot_move[d][i] = cur_move[i];
            end
        end
    endtask

    task automatic wait_idle();
        @(negedge clk_in);
        while (!idle_out) begin
            @(negedge clk_in);
        end
    endtask

    // one address per cycle, each word checked two cycles after its address
    task automatic read_slot(input depth_t d);
        for (int i = 0; i < slot_len[d] + 2; i++) begin
            @(posedge clk_in);
            if (i < slot_len[d]) begin
                read_depth_in <= d;
                read_idx_in   <= move_idx_t'(i);
            end
            @(negedge clk_in);
            if (i >= 2) begin
                check_value($sformatf("%s idx %0d", test_name, i - 2),
                            slot_move[d][i - 2], read_move_out);
            end
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    initial begin
        seed          = 32'hb1e7;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rst_in        = 1'b1;
        open_in       = 1'b0;
        close_in      = 1'b0;
        depth_in      = '0;
        move_in       = '0;
        eval_in       = '0;
        move_valid_in = 1'b0;
        read_depth_in = '0;
        read_idx_in   = '0;
        repeat (8) @(posedge clk_in);
        rst_in <= 1'b0;

        begin_test("reset");
        @(negedge clk_in);
        check_value("reset free", 16'd1, 16'(free_out));
        check_value("reset idle", 16'd1, 16'(idle_out));
        check_value("reset len valid", 16'd0, 16'(list_len_valid_out));
        end_test();

        d2 = depth_t'($random(seed));
        begin_test("random_40");
        run_list(d2, 40, 1'b0);
        wait_idle();
        read_slot(d2);
        end_test();

        begin_test("equal_evals");
        run_list(d2 ^ 5'd1, 30, 1'b1);
        wait_idle();
        read_slot(d2 ^ 5'd1);
        end_test();

        begin_test("back_to_back");
        run_list(d2 ^ 5'd2, 25, 1'b0);
        assert (!idle_out) else begin
            $display("first list drained before the second list was opened");
            error_count++;
        end
        run_list(d2 ^ 5'd3, 35, 1'b0);
        wait_idle();
        read_slot(d2 ^ 5'd2);
        read_slot(d2 ^ 5'd3);
        end_test();

        begin_test("overflow_70");
        run_list(d2 ^ 5'd4, 70, 1'b0);
        wait_idle();
        read_slot(d2 ^ 5'd4);
        end_test();

        begin_test("empty_list");
        // other sorter still draining, so free_out needs the released sorter
        run_list(d2 ^ 5'd5, 20, 1'b0);
        run_list(d2 ^ 5'd4, 0, 1'b0);
        check_value("empty_list free", 16'd1, 16'(free_out));
        wait_idle();
        read_slot(d2 ^ 5'd4);
        read_slot(d2 ^ 5'd5);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
chess_types_pkg.sv
move_order_pkg.sv
stream_sorter.sv
sorter_drain_arbiter.sv
move_stack_ram.sv
move_order_unit.sv
tb_move_order_unit.sv
